// File: sources.f
common/rst_ctrl_pkg.sv
regs/rst_ctrl_regs.sv
verilog/rst_req_collect.sv
verilog/grst_seq.sv
verilog/rst_ctrl_top.sv
testbench/rst_ctrl_props.sv
testbench/tb_rst_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# Build the reset controller testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_rst_ctrl -f sources.f

# The verdict comes from the log, so a stopped run still reaches the search
./obj_dir/Vtb_rst_ctrl > sim.log 2>&1 || true
cat sim.log

if grep -qx '\*\* PASS \*\*' sim.log; then
   exit 0
fi
exit 1

// File: testbench/tb_rst_ctrl.sv
// ==============================
// Reset controller testbench
// Clock, reset, register tasks, xorshift
// Read and timing checks, timeout
// ==============================

module tb_rst_ctrl
   import rst_ctrl_pkg::*;
();

   localparam int CLK_PERIOD     = 40;
   localparam int FALL_LIMIT     = 20;                      // Request to grst_n fall
   localparam int RISE_LIMIT     = int'(RST_DURATION) + 20;
   localparam int N_SEQ          = 8;                       // Reset sequences in the run
   localparam int SEQ_CYCLES     = 60;
   localparam int TIMEOUT_CYCLES = N_SEQ * SEQ_CYCLES * 5 + 600; // Margin for register traffic
   localparam int N_BAD          = 4;                       // Address monitor rounds
   localparam int BAD_SPAN       = 255 - int'(ADDR_MAX_VALID);

   logic               clk_in_ref;
   logic               hgrst_n;
   logic               wd_rst_req_i;
   logic               mips_cpu_rst_req_i;
   logic               mips_per_rst_req_i;
   logic               mips_hw_rst_cause_gpio_i;
   logic               mips_hw_rst_cause_gpio_en_i;
   logic               mips_hw_rst_cause_mips_wd_i;
   logic               mips_jtag_swrst_en_i;
   logic               scfg_sw_rst_mask_i;
   logic               scfg_mips_rst_mask_i;
   logic               reg_req_i;
   logic               reg_wr_i;
   logic [ADDR_W-1:0]  reg_addr_i;
   logic [DATA_W-1:0]  reg_wdata_i;
   logic [DATA_W-1:0]  reg_rdata_o;
   logic               grst_n_o;
   logic               pre_grst_n_ind_o;

   int           val_err_cnt  = 0;   // Wrong read values
   int           wait_err_cnt = 0;   // grst_n timing failures
   int           cycle_cnt    = 0;
   logic [31:0]  rng          = 32'h25b6e331;

   rst_ctrl_top i_rst_ctrl_top (
      .clk_in_ref                  (clk_in_ref),
      .hgrst_n                     (hgrst_n),
      .wd_rst_req_i                (wd_rst_req_i),
      .mips_cpu_rst_req_i          (mips_cpu_rst_req_i),
      .mips_per_rst_req_i          (mips_per_rst_req_i),
      .mips_hw_rst_cause_gpio_i    (mips_hw_rst_cause_gpio_i),
      .mips_hw_rst_cause_gpio_en_i (mips_hw_rst_cause_gpio_en_i),
      .mips_hw_rst_cause_mips_wd_i (mips_hw_rst_cause_mips_wd_i),
      .mips_jtag_swrst_en_i        (mips_jtag_swrst_en_i),
      .scfg_sw_rst_mask_i          (scfg_sw_rst_mask_i),
      .scfg_mips_rst_mask_i        (scfg_mips_rst_mask_i),
      .reg_req_i                   (reg_req_i),
      .reg_wr_i                    (reg_wr_i),
      .reg_addr_i                  (reg_addr_i),
      .reg_wdata_i                 (reg_wdata_i),
      .reg_rdata_o                 (reg_rdata_o),
      .grst_n_o                    (grst_n_o),
      .pre_grst_n_ind_o            (pre_grst_n_ind_o)
   );

   always #(CLK_PERIOD / 2) clk_in_ref = ~clk_in_ref;

   // Run limit, ends a hung sequence
   always @(posedge clk_in_ref)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES)
      begin
         $display("Timeout: test sequence still running after %0d cycles", TIMEOUT_CYCLES);
         $display("** FAIL **");
         $finish;
      end
   end

   // ==============================
   // Helpers
   // ==============================
   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Address strictly above the register map
   function automatic logic [ADDR_W-1:0] bad_addr(input logic [31:0] r);
      return ADDR_W'(int'(ADDR_MAX_VALID) + 1 + int'(r % BAD_SPAN));
   endfunction

   function automatic logic [DATA_W-1:0] cause_word(input int idx);
      return DATA_W'(1) << idx;    // One cause bit, zero-extended
   endfunction

   task automatic reg_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
      @(posedge clk_in_ref);
      reg_req_i   <= 1'b1;
      reg_wr_i    <= 1'b1;
      reg_addr_i  <= addr;
      reg_wdata_i <= data;
      @(posedge clk_in_ref);       // Write lands on this edge
      reg_req_i   <= 1'b0;
      reg_wr_i    <= 1'b0;
   endtask

   task automatic reg_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
      @(posedge clk_in_ref);
      reg_req_i  <= 1'b1;
      reg_wr_i   <= 1'b0;
      reg_addr_i <= addr;
      @(posedge clk_in_ref);
      reg_req_i  <= 1'b0;
      @(negedge clk_in_ref);       // Read data settled
      data = reg_rdata_o;
   endtask

   task automatic check_read(input string what, input logic [ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] exp);
      logic [DATA_W-1:0] got;
      reg_read(addr, got);
      assert (got === exp)
      else
      begin
         val_err_cnt++;
         $display("ERR reg_rdata_o (%s, addr %h): got %h expected %h", what, addr, got, exp);
      end
   endtask

   // grst_n low long enough, then released
   task automatic wait_release(input string what);
      int n;
      n = 0;
      while (grst_n_o !== 1'b1 && n < RISE_LIMIT)
      begin
         @(negedge clk_in_ref);
         n++;
      end
      assert (grst_n_o === 1'b1 && n >= int'(RST_DURATION))
      else
      begin
         wait_err_cnt++;
         $display("Global reset after %s lasted %0d cycles, expected %0d to %0d",
                  what, n, RST_DURATION, RISE_LIMIT);
      end
   endtask

   task automatic expect_reset(input string what);
      int n;
      n = 0;
      while (grst_n_o !== 1'b0 && n < FALL_LIMIT)
      begin
         @(negedge clk_in_ref);
         n++;
      end
      assert (grst_n_o === 1'b0)
      else
      begin
         wait_err_cnt++;
         $display("No global reset within %0d cycles of %s", FALL_LIMIT, what);
      end
      if (grst_n_o === 1'b0)
         wait_release(what);
   endtask

   task automatic hold_high(input int cycles, input string what);
      int  n;
      bit  fell_seen;
      fell_seen = 1'b0;
      for (n = 0; n < cycles; n++)
      begin
         @(negedge clk_in_ref);
         if (grst_n_o !== 1'b1)
            fell_seen = 1'b1;
      end
      assert (!fell_seen)
      else
      begin
         wait_err_cnt++;
         $display("Global reset asserted during %s, none expected", what);
      end
   endtask

   task automatic pulse_wd(input int cycles);
      @(posedge clk_in_ref);
      wd_rst_req_i <= 1'b1;
      repeat (cycles) @(posedge clk_in_ref);
      wd_rst_req_i <= 1'b0;
   endtask

   // ==============================
   // Test sequence
   // ==============================
   initial
   begin
      logic [ADDR_W-1:0]  bad_a;
      logic [ADDR_W-1:0]  bad_b;
      int                 i;
      int                 prop_err_cnt;
      clk_in_ref                  = 1'b0;
      hgrst_n                     = 1'b0;
      wd_rst_req_i                = 1'b0;
      mips_cpu_rst_req_i          = 1'b0;
      mips_per_rst_req_i          = 1'b0;
      mips_hw_rst_cause_gpio_i    = 1'b0;
      mips_hw_rst_cause_gpio_en_i = 1'b0;
      mips_hw_rst_cause_mips_wd_i = 1'b0;
      mips_jtag_swrst_en_i        = 1'b1;   // Triggers allowed
      scfg_sw_rst_mask_i          = 1'b0;
      scfg_mips_rst_mask_i        = 1'b0;
      reg_req_i                   = 1'b0;
      reg_wr_i                    = 1'b0;
      reg_addr_i                  = '0;
      reg_wdata_i                 = '0;
      repeat (16) @(posedge clk_in_ref);
      hgrst_n <= 1'b1;
      @(negedge clk_in_ref);
      assert (reg_rdata_o === '0)
      else
      begin
         val_err_cnt++;
         $display("ERR reg_rdata_o after reset: got %h expected %h", reg_rdata_o, 32'h0);
      end
      assert (grst_n_o === 1'b0)
      else
      begin
         val_err_cnt++;
         $display("ERR grst_n_o after reset: got %h expected %h", grst_n_o, 1'b0);
      end
      assert (pre_grst_n_ind_o === 1'b0)
      else
      begin
         val_err_cnt++;
         $display("ERR pre_grst_n_ind_o after reset: got %h expected %h",
                  pre_grst_n_ind_o, 1'b0);
      end

      // Power-up release and power-on cause
      wait_release("power-up");
      check_read("power-on cause", ADDR_CAUSE, cause_word(CAUSE_POR));
      reg_write(ADDR_CAUSE, '0);
      check_read("cleared cause", ADDR_CAUSE, '0);

      // Soft reset, locked then unlocked then masked
      reg_write(ADDR_SOFT_RESET, 32'h1);
      hold_high(100, "soft reset write while locked");
      check_read("cause after locked write", ADDR_CAUSE, '0);
      rng = xorshift32(rng);
      reg_write(ADDR_UNLOCK0, KICK_DATA0 ^ (rng | 32'h1));   // Never the kick word
      check_read("unlock0 after wrong word", ADDR_UNLOCK0, '0);
      reg_write(ADDR_UNLOCK0, KICK_DATA0);
      reg_write(ADDR_UNLOCK1, KICK_DATA1);
      check_read("unlock0", ADDR_UNLOCK0, 32'h1);
      check_read("unlock1", ADDR_UNLOCK1, 32'h1);
      reg_write(ADDR_SOFT_RESET, 32'h1);
      expect_reset("soft reset write");
      check_read("soft cause", ADDR_CAUSE, cause_word(CAUSE_SOFT));
      reg_write(ADDR_SOFT_RESET, 32'h0);   // Drop the level again
      reg_write(ADDR_CAUSE, '0);
      @(posedge clk_in_ref);
      scfg_sw_rst_mask_i <= 1'b1;
      reg_write(ADDR_SOFT_RESET, 32'h1);
      hold_high(100, "masked soft reset write");
      check_read("cause after masked write", ADDR_CAUSE, '0);
      @(posedge clk_in_ref);
      scfg_sw_rst_mask_i <= 1'b0;

      // Hardware sources
      pulse_wd(3);
      expect_reset("watchdog request");
      check_read("watchdog cause", ADDR_CAUSE, cause_word(CAUSE_WD));
      reg_write(ADDR_CAUSE, '0);
      @(posedge clk_in_ref);
      scfg_mips_rst_mask_i <= 1'b1;
      repeat (3) @(posedge clk_in_ref);   // Mask through its synchronizer first
      mips_cpu_rst_req_i <= 1'b1;
      repeat (3) @(posedge clk_in_ref);
      mips_cpu_rst_req_i <= 1'b0;
      hold_high(100, "masked CPU request");
      check_read("cause after masked CPU", ADDR_CAUSE, '0);
      @(posedge clk_in_ref);
      scfg_mips_rst_mask_i <= 1'b0;
      mips_per_rst_req_i   <= 1'b1;
      repeat (3) @(posedge clk_in_ref);
      mips_per_rst_req_i   <= 1'b0;
      expect_reset("peripheral request");
      check_read("peripheral cause", ADDR_CAUSE, cause_word(CAUSE_MIPS_PER));
      reg_write(ADDR_CAUSE, '0);
      @(posedge clk_in_ref);
      mips_hw_rst_cause_gpio_i    <= 1'b1;
      mips_hw_rst_cause_gpio_en_i <= 1'b1;
      hold_high(20, "GPIO cause");
      check_read("GPIO cause", ADDR_CAUSE, cause_word(CAUSE_GPIO));
      @(posedge clk_in_ref);
      mips_hw_rst_cause_gpio_i    <= 1'b0;
      mips_hw_rst_cause_gpio_en_i <= 1'b0;

      // JTAG enable low, cause only
      mips_jtag_swrst_en_i <= 1'b0;
      repeat (4) @(posedge clk_in_ref);
      reg_write(ADDR_CAUSE, '0);
      pulse_wd(3);
      hold_high(100, "watchdog with JTAG enable low");
      check_read("watchdog cause, JTAG low", ADDR_CAUSE, cause_word(CAUSE_WD));
      @(posedge clk_in_ref);
      mips_jtag_swrst_en_i <= 1'b1;

      // Address monitor with random unmapped addresses
      for (i = 0; i < N_BAD; i++)
      begin
         rng   = xorshift32(rng);
         bad_a = bad_addr(rng);
         do
         begin
            rng   = xorshift32(rng);
            bad_b = bad_addr(rng);
         end
         while (bad_b == bad_a);
         check_read("unmapped read", bad_a, BAD_RD_DATA);
         check_read("bad read address", ADDR_BAD_RD, DATA_W'(bad_a));
         rng = xorshift32(rng);
         reg_write(bad_b, rng);
         check_read("bad write address", ADDR_BAD_WR, DATA_W'(bad_b));
         check_read("valid read", ADDR_CAUSE, cause_word(CAUSE_WD));
         check_read("bad write address kept", ADDR_BAD_WR, DATA_W'(bad_b));
      end

      prop_err_cnt = i_rst_ctrl_top.i_rst_ctrl_props.fail_cnt;
      $display("Checks done: %0d value errors, %0d timing errors, %0d property errors",
               val_err_cnt, wait_err_cnt, prop_err_cnt);
      if (val_err_cnt == 0 && wait_err_cnt == 0 && prop_err_cnt == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

// File: testbench/rst_ctrl_props.sv
// ==============================
// Concurrent checks on reset timing
// Pre-indication, hold time, read data, trigger origin
// ==============================

module rst_ctrl_props
   import rst_ctrl_pkg::*;
(
   input  logic               clk_in_ref,
   input  logic               hgrst_n,
   input  logic               reg_req_i,
   input  logic               grst_req_i,
   input  logic               grst_n_i,
   input  logic               pre_grst_n_ind_i,
   input  logic [DATA_W-1:0]  reg_rdata_i
);

   logic [CNT_W-1:0]  low_cnt;    // Edges with grst_n low
   logic              grst_n_q;
   logic              req_q;
   logic              req_seen;   // Trigger rose since last fall
   int                fail_cnt = 0;   // Failed properties so far

   always_ff @(posedge clk_in_ref or negedge hgrst_n)
   begin
      if (!hgrst_n)
      begin
         low_cnt  <= '0;
         grst_n_q <= 1'b0;
         req_q    <= 1'b0;
         req_seen <= 1'b0;
      end
      else
      begin
         grst_n_q <= grst_n_i;
         req_q    <= grst_req_i;
         if (grst_n_i)
            low_cnt <= '0;
         else if (low_cnt != '1)
            low_cnt <= low_cnt + CNT_W'(1);   // Saturates
         if (grst_req_i && !req_q)
            req_seen <= 1'b1;
         else if (!grst_n_i && grst_n_q)
            req_seen <= 1'b0;                 // Used up by this fall
      end
   end

   // ==============================
   // Properties
   // ==============================
   pre_ind_before_rise: assert property (@(posedge clk_in_ref) disable iff (!hgrst_n)
      $rose(grst_n_i) |-> $past(pre_grst_n_ind_i))
      else
      begin
         fail_cnt++;
         $error("grst_n_o rose without pre-indication the cycle before");
      end

   low_hold_time: assert property (@(posedge clk_in_ref) disable iff (!hgrst_n)
      $rose(grst_n_i) |-> low_cnt >= RST_DURATION)
      else
      begin
         fail_cnt++;
         $error("grst_n_o released before the reset duration ran out");
      end

   rdata_known: assert property (@(posedge clk_in_ref) disable iff (!hgrst_n)
      !$isunknown(reg_rdata_i))
      else
      begin
         fail_cnt++;
         $error("reg_rdata_o is unknown after reset");
      end

   fall_has_trigger: assert property (@(posedge clk_in_ref) disable iff (!hgrst_n)
      $fell(grst_n_i) && !reg_req_i |-> req_seen)
      else
      begin
         fail_cnt++;
         $error("grst_n_o fell with no earlier trigger rise");
      end

endmodule

bind rst_ctrl_top rst_ctrl_props i_rst_ctrl_props (
   .clk_in_ref       (clk_in_ref),
   .hgrst_n          (hgrst_n),
   .reg_req_i        (reg_req_i),
   .grst_req_i       (grst_req),
   .grst_n_i         (grst_n_o),
   .pre_grst_n_ind_i (pre_grst_n_ind_o),
   .reg_rdata_i      (reg_rdata_o)
);

// File: verilog/rst_ctrl_top.sv
// ==============================
// Reset controller top level
// Register block, request collector, global reset sequencer
// ==============================

module rst_ctrl_top
   import rst_ctrl_pkg::*;
(
   input  logic                clk_in_ref,
   input  logic                hgrst_n,
   input  logic                wd_rst_req_i,
   input  logic                mips_cpu_rst_req_i,
   input  logic                mips_per_rst_req_i,
   input  logic                mips_hw_rst_cause_gpio_i,
   input  logic                mips_hw_rst_cause_gpio_en_i,
   input  logic                mips_hw_rst_cause_mips_wd_i,
   input  logic                mips_jtag_swrst_en_i,
   input  logic                scfg_sw_rst_mask_i,
   input  logic                scfg_mips_rst_mask_i,
   input  logic                reg_req_i,
   input  logic                reg_wr_i,
   input  logic [ADDR_W-1:0]   reg_addr_i,
   input  logic [DATA_W-1:0]   reg_wdata_i,
   output logic [DATA_W-1:0]   reg_rdata_o,
   output logic                grst_n_o,
   output logic                pre_grst_n_ind_o
);

   logic                soft_rst;     // Soft reset level from registers
   logic [N_SRC_W-1:0]  cause_src;    // Source levels for the cause register
   logic                grst_req;     // Qualified trigger level

   rst_ctrl_regs i_rst_ctrl_regs (
      .clk_in_ref         (clk_in_ref),
      .hgrst_n            (hgrst_n),
      .reg_req_i          (reg_req_i),
      .reg_wr_i           (reg_wr_i),
      .reg_addr_i         (reg_addr_i),
      .reg_wdata_i        (reg_wdata_i),
      .scfg_sw_rst_mask_i (scfg_sw_rst_mask_i),
      .cause_src_i        (cause_src),
      .reg_rdata_o        (reg_rdata_o),
      .soft_rst_o         (soft_rst)
   );

   rst_req_collect i_rst_req_collect (
      .clk_in_ref                  (clk_in_ref),
      .hgrst_n                     (hgrst_n),
      .wd_rst_req_i                (wd_rst_req_i),
      .mips_cpu_rst_req_i          (mips_cpu_rst_req_i),
      .mips_per_rst_req_i          (mips_per_rst_req_i),
      .mips_hw_rst_cause_gpio_i    (mips_hw_rst_cause_gpio_i),
      .mips_hw_rst_cause_gpio_en_i (mips_hw_rst_cause_gpio_en_i),
      .mips_hw_rst_cause_mips_wd_i (mips_hw_rst_cause_mips_wd_i),
      .mips_jtag_swrst_en_i        (mips_jtag_swrst_en_i),
      .scfg_mips_rst_mask_i        (scfg_mips_rst_mask_i),
      .soft_rst_i                  (soft_rst),
      .cause_src_o                 (cause_src),
      .grst_req_o                  (grst_req)
   );

   grst_seq i_grst_seq (
      .clk_in_ref       (clk_in_ref),
      .hgrst_n          (hgrst_n),
      .grst_req_i       (grst_req),
      .grst_n_o         (grst_n_o),
      .pre_grst_n_ind_o (pre_grst_n_ind_o)
   );

endmodule

// File: verilog/grst_seq.sv
// ==============================
// Global reset sequencer
// Request edge detect and 3-cycle stretch
// Duration counter, grst_n and its early warning
// ==============================

module grst_seq
   import rst_ctrl_pkg::*;
(
   input  logic  clk_in_ref,
   input  logic  hgrst_n,
   input  logic  grst_req_i,
   output logic  grst_n_o,
   output logic  pre_grst_n_ind_o
);

   logic              req_q;
   logic              req_d1;
   logic              req_pls;        // One cycle on request rise
   logic              pls_d1;
   logic              pls_d2;
   logic              pls_d3;
   logic              strch_q;        // Stretched request level
   logic [CNT_W-1:0]  grst_cnt;
   logic              grst_n_q;
   logic              pre_ind_q;

   // ==============================
   // Edge detect and stretch
   // ==============================
   assign req_pls = req_q & ~req_d1;  // Held level fires once

   always_ff @(posedge clk_in_ref or negedge hgrst_n)
   begin
      if (!hgrst_n)
      begin
         req_q   <= 1'b0;
         req_d1  <= 1'b0;
         pls_d1  <= 1'b0;
         pls_d2  <= 1'b0;
         pls_d3  <= 1'b0;
         strch_q <= 1'b0;
      end
      else
      begin
         req_q   <= grst_req_i;
         req_d1  <= req_q;
         pls_d1  <= req_pls;
         pls_d2  <= pls_d1;
         pls_d3  <= pls_d2;
         strch_q <= pls_d1 | pls_d2 | pls_d3; // Three cycles wide
      end
   end

   // ==============================
   // Duration counter and outputs
   // ==============================
   always_ff @(posedge clk_in_ref or negedge hgrst_n)
   begin
      if (!hgrst_n)
      begin
         grst_cnt  <= '0;
         grst_n_q  <= 1'b0;   // In reset from power-up
         pre_ind_q <= 1'b0;
      end
      else
      begin
         if (strch_q)
            grst_cnt <= '0;   // Restart on every request
         else if (grst_cnt < RST_DURATION)
            grst_cnt <= grst_cnt + CNT_W'(1);

         if (grst_cnt == RST_DURATION)
            grst_n_q <= ~strch_q;  // Idle, drop on new request
         else if (grst_cnt < RST_DURATION)
            grst_n_q <= 1'b0;

         // Warning over the last cycles before release
         pre_ind_q <= (grst_cnt > (RST_DURATION - PRE_IND_LEAD)) & ~grst_n_q;
      end
   end

   assign grst_n_o         = grst_n_q;
   assign pre_grst_n_ind_o = pre_ind_q;

endmodule

// File: verilog/rst_req_collect.sv
// ==============================
// Reset request collector
// Synchronizes sources, applies masks and JTAG enable
// Builds the cause vector and the trigger level
// ==============================

module rst_req_collect
   import rst_ctrl_pkg::*;
(
   input  logic                clk_in_ref,
   input  logic                hgrst_n,
   input  logic                wd_rst_req_i,
   input  logic                mips_cpu_rst_req_i,
   input  logic                mips_per_rst_req_i,
   input  logic                mips_hw_rst_cause_gpio_i,
   input  logic                mips_hw_rst_cause_gpio_en_i,
   input  logic                mips_hw_rst_cause_mips_wd_i,
   input  logic                mips_jtag_swrst_en_i,
   input  logic                scfg_mips_rst_mask_i,
   input  logic                soft_rst_i,
   output logic [N_SRC_W-1:0]  cause_src_o,
   output logic                grst_req_o
);

   logic [N_SYNC-1:0]  sync_d;
   logic [N_SYNC-1:0]  sync_ff [0:1];   // Two-flop synchronizer stages
   logic               wd_s;
   logic               cpu_s;
   logic               per_s;
   logic               mask_s;
   logic               gpio_s;
   logic               gpio_en_s;
   logic               jtag_en_s;
   logic               wd_d;            // Trigger copies, one cycle late
   logic               cpu_d;
   logic               per_d;
   logic               soft_d;

   assign sync_d = {mips_jtag_swrst_en_i, mips_hw_rst_cause_gpio_en_i, mips_hw_rst_cause_gpio_i,
                    scfg_mips_rst_mask_i, mips_per_rst_req_i, mips_cpu_rst_req_i, wd_rst_req_i};

   always_ff @(posedge clk_in_ref or negedge hgrst_n)
   begin
      if (!hgrst_n)
      begin
         sync_ff[0] <= '0;
         sync_ff[1] <= '0;
      end
      else
      begin
         sync_ff[0] <= sync_d;
         sync_ff[1] <= sync_ff[0];
      end
   end

   assign {jtag_en_s, gpio_en_s, gpio_s, mask_s, per_s, cpu_s, wd_s} = sync_ff[1];

   // Cause vector, masked MIPS requests drop out here
   assign cause_src_o[CAUSE_SOFT]     = soft_rst_i;
   assign cause_src_o[CAUSE_MIPS_PER] = per_s & ~mask_s;
   assign cause_src_o[CAUSE_MIPS_CPU] = cpu_s & ~mask_s;
   assign cause_src_o[CAUSE_WD]       = wd_s;
   assign cause_src_o[CAUSE_GPIO]     = gpio_s & gpio_en_s;  // Cause only, no reset
   assign cause_src_o[CAUSE_MIPS_WD]  = mips_hw_rst_cause_mips_wd_i; // Already local

   // Delay so the cause register captures before sequencing starts
   always_ff @(posedge clk_in_ref or negedge hgrst_n)
   begin
      if (!hgrst_n)
      begin
         wd_d   <= 1'b0;
         cpu_d  <= 1'b0;
         per_d  <= 1'b0;
         soft_d <= 1'b0;
      end
      else
      begin
         wd_d   <= cause_src_o[CAUSE_WD];
         cpu_d  <= cause_src_o[CAUSE_MIPS_CPU];
         per_d  <= cause_src_o[CAUSE_MIPS_PER];
         soft_d <= cause_src_o[CAUSE_SOFT];
      end
   end

   assign grst_req_o = (wd_d | cpu_d | per_d | soft_d) & jtag_en_s; // JTAG low blocks all

endmodule

// File: regs/rst_ctrl_regs.sv
// ==============================
// Reset controller register block
// Unlock pair, soft reset, sticky cause register
// Bad read and bad write address capture, registered read data
// ==============================

module rst_ctrl_regs
   import rst_ctrl_pkg::*;
(
   input  logic                clk_in_ref,
   input  logic                hgrst_n,
   input  logic                reg_req_i,
   input  logic                reg_wr_i,
   input  logic [ADDR_W-1:0]   reg_addr_i,
   input  logic [DATA_W-1:0]   reg_wdata_i,
   input  logic                scfg_sw_rst_mask_i,
   input  logic [N_SRC_W-1:0]  cause_src_i,
   output logic [DATA_W-1:0]   reg_rdata_o,
   output logic                soft_rst_o
);

   logic                wr_acc;          // Write strobe this cycle
   logic                rd_acc;          // Read strobe this cycle
   logic                unlock0_q;
   logic                unlock1_q;
   logic                unlocked;
   logic                soft_rst_q;
   logic [CAUSE_W-1:0]  cause_q;
   logic                cause_any;
   logic                cause_any_q;     // Rise detect of cause OR
   logic [ADDR_W-1:0]   bad_rd_addr_q;
   logic [ADDR_W-1:0]   bad_wr_addr_q;
   logic [DATA_W-1:0]   rdata_q;
   logic [DATA_W-1:0]   rdata_t;         // Decoded read value
   logic                rd_bad;          // Read of unmapped address

   assign wr_acc   = reg_req_i & reg_wr_i;
   assign rd_acc   = reg_req_i & ~reg_wr_i;
   assign unlocked = unlock0_q & unlock1_q;

   // ==============================
   // Unlock pair and soft reset
   // ==============================
   always_ff @(posedge clk_in_ref or negedge hgrst_n)
   begin
      if (!hgrst_n)
      begin
         unlock0_q  <= 1'b0;
         unlock1_q  <= 1'b0;
         soft_rst_q <= 1'b0;
      end
      else
      begin
         // Sticky once the right word lands
         if (wr_acc && reg_addr_i == ADDR_UNLOCK0 && reg_wdata_i == KICK_DATA0)
            unlock0_q <= 1'b1;
         // Second word only counts after the first
         if (wr_acc && reg_addr_i == ADDR_UNLOCK1 && reg_wdata_i == KICK_DATA1 && unlock0_q)
            unlock1_q <= 1'b1;
         if (wr_acc && reg_addr_i == ADDR_SOFT_RESET && unlocked && !scfg_sw_rst_mask_i)
            soft_rst_q <= reg_wdata_i[0]; // Level, stays until rewritten
      end
   end

   assign soft_rst_o = soft_rst_q;

   // ==============================
   // Sticky cause register
   // ==============================
   assign cause_any = |cause_src_i;

   always_ff @(posedge clk_in_ref or negedge hgrst_n)
   begin
      if (!hgrst_n)
      begin
         cause_q     <= CAUSE_RESET_VAL; // Power-on cause shows first
         cause_any_q <= 1'b0;
      end
      else
      begin
         cause_any_q <= cause_any;
         if (cause_any && !cause_any_q)
            cause_q <= CAUSE_W'(cause_src_i); // First rise wins over clear
         else if (wr_acc && reg_addr_i == ADDR_CAUSE)
            cause_q <= '0;
      end
   end

   // ==============================
   // Read decode and address monitor
   // ==============================
   always_comb
   begin
      rd_bad  = 1'b0;
      rdata_t = '0;
      case (reg_addr_i)
         ADDR_SOFT_RESET : rdata_t = '0;              // Write-only in effect
         ADDR_CAUSE      : rdata_t = DATA_W'(cause_q);
         ADDR_UNLOCK0    : rdata_t = DATA_W'(unlock0_q);
         ADDR_UNLOCK1    : rdata_t = DATA_W'(unlock1_q);
         ADDR_BAD_RD     : rdata_t = DATA_W'(bad_rd_addr_q);
         ADDR_BAD_WR     : rdata_t = DATA_W'(bad_wr_addr_q);
         default :
         begin
            rdata_t = BAD_RD_DATA; // Unmapped, includes unaligned
            rd_bad  = 1'b1;
         end
      endcase
   end

   always_ff @(posedge clk_in_ref or negedge hgrst_n)
   begin
      if (!hgrst_n)
      begin
         rdata_q       <= '0;
         bad_rd_addr_q <= '0;
         bad_wr_addr_q <= '0;
      end
      else
      begin
         if (rd_acc)
            rdata_q <= rdata_t;          // Held until next read
         if (rd_acc && rd_bad)
            bad_rd_addr_q <= reg_addr_i;
         // Only writes past the map are flagged
         if (wr_acc && reg_addr_i > ADDR_MAX_VALID)
            bad_wr_addr_q <= reg_addr_i;
      end
   end

   assign reg_rdata_o = rdata_q;

endmodule

// File: common/rst_ctrl_pkg.sv
// ==============================
// Reset controller package
// Register map, unlock words, reset duration and cause bit layout
// ==============================

package rst_ctrl_pkg;

   // Register port widths
   localparam int ADDR_W = 8;
   localparam int DATA_W = 32;

   // ==============================
   // Register map, one word apart
   // ==============================
   localparam logic [ADDR_W-1:0] ADDR_SOFT_RESET = 8'h00;
   localparam logic [ADDR_W-1:0] ADDR_CAUSE      = 8'h04;
   localparam logic [ADDR_W-1:0] ADDR_UNLOCK0    = 8'h08;
   localparam logic [ADDR_W-1:0] ADDR_UNLOCK1    = 8'h0C;
   localparam logic [ADDR_W-1:0] ADDR_BAD_RD     = 8'h10;
   localparam logic [ADDR_W-1:0] ADDR_BAD_WR     = 8'h14;
   localparam logic [ADDR_W-1:0] ADDR_MAX_VALID  = ADDR_BAD_WR; // Writes above are bad

   // Unlock kick words, written in this order
   localparam logic [DATA_W-1:0] KICK_DATA0  = 32'h20406080;
   localparam logic [DATA_W-1:0] KICK_DATA1  = 32'h10305070;
   localparam logic [DATA_W-1:0] BAD_RD_DATA = 32'hBABADBAD; // Marker for unmapped reads

   // Global reset timing
   localparam int                CNT_W        = 16;
   localparam logic [CNT_W-1:0]  RST_DURATION = 16'd40; // Cycles held low
   localparam logic [CNT_W-1:0]  PRE_IND_LEAD = 16'd5;  // Warning lead

   // ==============================
   // Cause register layout
   // ==============================
   localparam int CAUSE_W        = 7;
   localparam int CAUSE_SOFT     = 0;
   localparam int CAUSE_MIPS_PER = 1;
   localparam int CAUSE_MIPS_CPU = 2;
   localparam int CAUSE_WD       = 3;
   localparam int CAUSE_GPIO     = 4;
   localparam int CAUSE_MIPS_WD  = 5;
   localparam int CAUSE_POR      = 6;

   localparam logic [CAUSE_W-1:0] CAUSE_RESET_VAL = CAUSE_W'(1 << CAUSE_POR); // Reads 0x40

   localparam int N_SRC_W = 6; // Cause bits 0 to 5 come from sources
   localparam int N_SYNC  = 7; // Inputs through the 2-flop synchronizer

endpackage
